// ==== include/mlpNet_consts.svh ====
`ifndef MLPNET_CONSTS_SVH
`define MLPNET_CONSTS_SVH

// --------------------
// Network shape
// --------------------
`define FEATURE_COUNT 4
`define HIDDEN_COUNT 4
`define CLASS_COUNT 3

// Node output is sum bits [FRAC_SHIFT+15:FRAC_SHIFT].
`define FRAC_SHIFT 13

// Edges from an input vector to a node output, and to classIndex.
`define NODE_LATENCY 3
`define NETWORK_LATENCY 7

// --------------------
// Weights and biases
// --------------------
// Word n*inputCount+i is the weight of input i in node n.
// Word 0 is the rightmost entry; each row lists node n, inputs 3 down to 0.
`define HIDDEN_WEIGHTS { \
	32'sd3127,   -32'sd610,   32'sd159,    32'sd1506, \
	32'sd3366,   32'sd3848,   32'sd887,    -32'sd2941, \
	32'sd2017,   32'sd6829,   -32'sd2215,  32'sd5879, \
	32'sd1056,   32'sd5666,   32'sd4405,   32'sd2149 \
}

`define HIDDEN_BIASES { \
	32'sd840,    -32'sd3000,  32'sd512,    -32'sd1228 \
}

// Three output nodes over four hidden activations.
`define OUTPUT_WEIGHTS { \
	32'sd2901,   -32'sd3790,  32'sd2333,   32'sd1560, \
	32'sd1877,   32'sd998,    32'sd4120,   -32'sd2604, \
	32'sd1735,   32'sd2280,   -32'sd1450,  32'sd3012 \
}

`define OUTPUT_BIASES { \
	32'sd1024,   -32'sd640,   32'sd256 \
}

`endif

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# The exit status is nonzero when the build fails or the testbench stops with $fatal.
cd "$(dirname "$0")" &&
verilator --binary --timing -f sim.f \
	--top-module mlpNetwork_tb \
	--Mdir obj_dir -o mlpNetwork_sim &&
./obj_dir/mlpNetwork_sim ||
{
	echo "Simulation run did not complete cleanly."
	exit 1
}

// ==== sim.f ====
+incdir+include
source/mlpPkg.sv
source/activationBus.sv
source/neuronNode.sv
source/denseLayer.sv
source/classSelector.sv
source/mlpNetwork.sv
verif/mlpNetwork_tb.sv

// ==== source/activationBus.sv ====
`timescale 1ns/100ps

// One word per lane, updated every clock with no strobe.
interface activationBus
	import mlpPkg::*;
#(
	parameter int laneCount = 4
);

	activation_t lane [laneCount]; // Current activation level of each lane.

	// --------------------
	// Views
	// --------------------
	modport producer
	(
		output lane
	);

	modport consumer
	(
		input lane
	);

endinterface

// ==== source/classSelector.sv ====
`timescale 1ns/100ps

module classSelector
	import mlpPkg::*;
#(
	parameter int classCount = 3
)
(
	input logic clk,
	input logic reset,
	activationBus.consumer scoreBus,
	output classIndex_t classIndex
);

	localparam int scoreWidth = $bits(score_t);

	score_t laneScore [classCount];
	score_t bestScore;
	classIndex_t bestIndex;

	// --------------------
	// Argmax
	// --------------------
	always_comb
	begin
		for (int c = 0; c < classCount; c++)
		begin
			laneScore[c] = scoreBus.lane[c][scoreWidth-1:0];
		end
	end

	// Strict compare, so an equal later score never displaces an earlier one.
	always_comb
	begin
		bestScore = laneScore[0];
		bestIndex = '0;
		for (int c = 1; c < classCount; c++)
		begin
			if (laneScore[c] > bestScore)
			begin
				bestScore = laneScore[c];
				bestIndex = classIndex_t'(c);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			classIndex <= '0;
		end
		else
		begin
			classIndex <= bestIndex;
		end
	end

	// The chosen lane holds the largest score and no earlier lane reaches it.
	generate
		for (genvar c = 0; c < classCount; c++)
		begin : gMaxCheck
			assert property (@(posedge clk) disable iff (reset)
				int'(bestIndex) < classCount
					&& laneScore[c] <= laneScore[bestIndex]
					&& (c >= int'(bestIndex) || laneScore[c] < laneScore[bestIndex]))
			else
				$error("classSelector did not pick the first largest score.");
		end
	endgenerate

endmodule

// ==== source/denseLayer.sv ====
`timescale 1ns/100ps

module denseLayer
	import mlpPkg::*;
#(
	parameter int inputCount = 4,
	parameter int nodeCount = 4,
	parameter activation_t [inputCount*nodeCount-1:0] weightMatrix = '0,
	parameter activation_t [nodeCount-1:0] biasVector = '0
)
(
	input logic clk,
	input logic reset,
	activationBus.consumer inBus,
	activationBus.producer outBus
);

	activation_t nodeOut [nodeCount]; // One rectified word per node.

	// --------------------
	// Node array
	// --------------------
	// Every node sees all input lanes; node n takes row n of the matrix.
	generate
		for (genvar n = 0; n < nodeCount; n++)
		begin : gNode
			localparam activation_t [inputCount-1:0] rowWeights =
				weightMatrix[n*inputCount +: inputCount];
			localparam activation_t rowBias = biasVector[n];

			neuronNode
			#(
				.inputCount(inputCount),
				.weights(rowWeights),
				.bias(rowBias)
			)
			node
			(
				.clk(clk),
				.reset(reset),
				.inputs(inBus.lane),
				.activation(nodeOut[n])
			);
		end
	endgenerate

	// --------------------
	// Layer output
	// --------------------
	assign outBus.lane = nodeOut; // All nodes finish on the same edge.

endmodule

// ==== source/mlpNetwork.sv ====
`timescale 1ns/100ps

`include "mlpNet_consts.svh"

module mlpNetwork
	import mlpPkg::*;
(
	input logic clk,
	input logic reset,
	input activation_t feature0,
	input activation_t feature1,
	input activation_t feature2,
	input activation_t feature3,
	output score_t score0,
	output score_t score1,
	output score_t score2,
	output classIndex_t classIndex
);

	localparam int scoreWidth = $bits(score_t);

	// --------------------
	// Layer buses
	// --------------------
	activationBus #(.laneCount(`FEATURE_COUNT)) featureBus ();
	activationBus #(.laneCount(`HIDDEN_COUNT)) hiddenBus ();
	activationBus #(.laneCount(`CLASS_COUNT)) scoreBus ();

	assign featureBus.lane[0] = feature0;
	assign featureBus.lane[1] = feature1;
	assign featureBus.lane[2] = feature2;
	assign featureBus.lane[3] = feature3;

	// --------------------
	// Dense layers
	// --------------------
	denseLayer
	#(
		.inputCount(`FEATURE_COUNT),
		.nodeCount(`HIDDEN_COUNT),
		.weightMatrix(`HIDDEN_WEIGHTS),
		.biasVector(`HIDDEN_BIASES)
	)
	hiddenLayer
	(
		.clk(clk),
		.reset(reset),
		.inBus(featureBus.consumer),
		.outBus(hiddenBus.producer)
	);

	denseLayer
	#(
		.inputCount(`HIDDEN_COUNT),
		.nodeCount(`CLASS_COUNT),
		.weightMatrix(`OUTPUT_WEIGHTS),
		.biasVector(`OUTPUT_BIASES)
	)
	outputLayer
	(
		.clk(clk),
		.reset(reset),
		.inBus(hiddenBus.consumer),
		.outBus(scoreBus.producer)
	);

	// --------------------
	// Results
	// --------------------
	assign score0 = scoreBus.lane[0][scoreWidth-1:0]; // Upper half is always zero.
	assign score1 = scoreBus.lane[1][scoreWidth-1:0];
	assign score2 = scoreBus.lane[2][scoreWidth-1:0];

	classSelector
	#(
		.classCount(`CLASS_COUNT)
	)
	argmaxSelector
	(
		.clk(clk),
		.reset(reset),
		.scoreBus(scoreBus.consumer),
		.classIndex(classIndex)
	);

endmodule

// ==== source/mlpPkg.sv ====
package mlpPkg;

	// --------------------
	// Datapath words
	// --------------------

	// Features, products, sums and node outputs all share this width.
	typedef logic [31:0] activation_t;

	// Rescaled node output as seen by the class selector.
	typedef logic [15:0] score_t;

	// --------------------
	// Classification
	// --------------------

	// Enough for the three output classes.
	typedef logic [1:0] classIndex_t;

endpackage

// ==== source/neuronNode.sv ====
`timescale 1ns/100ps

`include "mlpNet_consts.svh"

module neuronNode
	import mlpPkg::*;
#(
	parameter int inputCount = 4,
	parameter activation_t [inputCount-1:0] weights = '0,
	parameter activation_t bias = '0
)
(
	input logic clk,
	input logic reset,
	input activation_t inputs [inputCount],
	output activation_t activation
);

	localparam int scoreWidth = $bits(score_t);
	localparam int wordWidth = $bits(activation_t);

	activation_t inputReg [inputCount]; // Sampled activations.
	activation_t products [inputCount];
	activation_t sumNext;
	activation_t sumReg; // Wrapping weighted sum plus bias.
	logic inputsZero; // Every sampled activation is zero.

	// --------------------
	// Input stage
	// --------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < inputCount; i++)
			begin
				inputReg[i] <= '0;
			end
		end
		else
		begin
			inputReg <= inputs;
		end
	end

	// --------------------
	// Multiply and sum
	// --------------------
	// Products keep only the low 32 bits, as does the running sum.
	always_comb
	begin
		for (int i = 0; i < inputCount; i++)
		begin
			products[i] = inputReg[i] * weights[i];
		end
	end

	always_comb
	begin
		sumNext = bias;
		for (int i = 0; i < inputCount; i++)
		begin
			sumNext = sumNext + products[i];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
		end
		else
		begin
			sumReg <= sumNext;
		end
	end

	// --------------------
	// Rectify and rescale
	// --------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			activation <= '0;
		end
		else if (sumReg[wordWidth-1])
		begin
			activation <= '0; // Negative sums are clipped.
		end
		else
		begin
			activation <= activation_t'(sumReg[`FRAC_SHIFT +: scoreWidth]);
		end
	end

	always_comb
	begin
		inputsZero = 1'b1;
		for (int i = 0; i < inputCount; i++)
		begin
			if (inputReg[i] != '0)
			begin
				inputsZero = 1'b0;
			end
		end
	end

	// A zero input vector leaves only the bias in the sum one edge later.
	assert property (@(posedge clk) disable iff (reset)
		!$past(reset) && $past(inputsZero) |-> sumReg == bias)
	else
		$error("neuronNode sum does not equal its bias for a zero input.");

endmodule

// ==== verif/mlpNetwork_tb.sv ====
`timescale 1ns/100ps

`include "mlpNet_consts.svh"

module mlpNetwork_tb
	import mlpPkg::*;
;

	localparam int resetCycles = 3;
	localparam int smallCount = 240;
	localparam int skewedCount = 80;
	localparam int zeroCount = 8;
	localparam int fullCount = 80;
	localparam int drainCount = `NETWORK_LATENCY;
	localparam int vectorTotal = smallCount + skewedCount + zeroCount + fullCount + drainCount;
	localparam int cycleLimit = resetCycles + vectorTotal + `NETWORK_LATENCY + 32;

	// Scores leave one edge before the class index.
	localparam int scoreDelay = `NETWORK_LATENCY - 1;
	localparam int classDelay = `NETWORK_LATENCY;

	localparam activation_t [`FEATURE_COUNT*`HIDDEN_COUNT-1:0] hiddenWeights = `HIDDEN_WEIGHTS;
	localparam activation_t [`HIDDEN_COUNT-1:0] hiddenBiases = `HIDDEN_BIASES;
	localparam activation_t [`HIDDEN_COUNT*`CLASS_COUNT-1:0] outputWeights = `OUTPUT_WEIGHTS;
	localparam activation_t [`CLASS_COUNT-1:0] outputBiases = `OUTPUT_BIASES;

	logic clk = 1'b0;
	logic reset;
	activation_t feature0;
	activation_t feature1;
	activation_t feature2;
	activation_t feature3;
	score_t score0;
	score_t score1;
	score_t score2;
	classIndex_t classIndex;

	logic [31:0] rngState;
	int cycleCount = 0;
	int hiddenNegCount = 0;
	int outputNegCount = 0;
	int tieCount = 0;
	int wrapCount = 0;

	score_t [`CLASS_COUNT-1:0] scoreQ [$]; // Expected scores, oldest vector first.
	classIndex_t classQ [$];

	mlpNetwork i_dut
	(
		.clk(clk),
		.reset(reset),
		.feature0(feature0),
		.feature1(feature1),
		.feature2(feature2),
		.feature3(feature3),
		.score0(score0),
		.score1(score1),
		.score2(score2),
		.classIndex(classIndex)
	);

	always #2 clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount > cycleLimit)
		begin
			failRun("Timeout: the run went past its cycle limit.");
		end
	end

	// --------------------
	// Helpers
	// --------------------
	function automatic logic [31:0] nextRandom();
		rngState = rngState * 32'd1664525 + 32'd1013904223;
		return rngState;
	endfunction

	task automatic failRun(input string reason);
		$display("Test failures found");
		$fatal(1, reason);
	endtask

	task automatic checkScore(input string name, input score_t expected, input score_t actual);
		if (actual !== expected)
		begin
			$display("Error: %s expected 0x%h got 0x%h", name, expected, actual);
			failRun("Score mismatch.");
		end
	endtask

	task automatic checkClass(input string name, input classIndex_t expected,
		input classIndex_t actual);
		if (actual !== expected)
		begin
			$display("Error: %s expected 0x%h got 0x%h", name, expected, actual);
			failRun("Class index mismatch.");
		end
	endtask

	// --------------------
	// Reference model
	// --------------------
	// ReLU, then keep sum bits 28 down to 13.
	function automatic activation_t rectify(input activation_t sum);
		if (sum[31])
		begin
			return '0;
		end
		return {16'b0, sum[`FRAC_SHIFT +: 16]};
	endfunction

	task automatic modelVector(input activation_t f [`FEATURE_COUNT],
		output score_t [`CLASS_COUNT-1:0] scores, output classIndex_t best);
		activation_t hidden [`HIDDEN_COUNT];
		activation_t sum;
		activation_t outAct;
		longint exact;
		score_t bestScore;
		logic tied;
		for (int n = 0; n < `HIDDEN_COUNT; n++)
		begin
			sum = hiddenBiases[n];
			exact = longint'($signed(hiddenBiases[n]));
			for (int i = 0; i < `FEATURE_COUNT; i++)
			begin
				sum = sum + f[i] * hiddenWeights[n*`FEATURE_COUNT + i];
				exact = exact + longint'(f[i])
					* longint'($signed(hiddenWeights[n*`FEATURE_COUNT + i]));
			end
			if (exact != longint'($signed(sum)))
			begin
				wrapCount++; // The 32-bit sum differs from the true sum.
			end
			if (sum[31])
			begin
				hiddenNegCount++;
			end
			hidden[n] = rectify(sum);
		end
		for (int c = 0; c < `CLASS_COUNT; c++)
		begin
			sum = outputBiases[c];
			for (int h = 0; h < `HIDDEN_COUNT; h++)
			begin
				sum = sum + hidden[h] * outputWeights[c*`HIDDEN_COUNT + h];
			end
			if (sum[31])
			begin
				outputNegCount++;
			end
			outAct = rectify(sum);
			scores[c] = outAct[15:0];
		end
		// Largest score wins; among equals the lowest index.
		best = '0;
		bestScore = scores[0];
		for (int c = 1; c < `CLASS_COUNT; c++)
		begin
			if (scores[c] > bestScore)
			begin
				bestScore = scores[c];
				best = classIndex_t'(c);
			end
		end
		tied = 1'b0;
		for (int c = 0; c < `CLASS_COUNT; c++)
		begin
			if (c != int'(best) && scores[c] == bestScore)
			begin
				tied = 1'b1;
			end
		end
		if (tied)
		begin
			tieCount++;
		end
	endtask

	// --------------------
	// Stimulus
	// --------------------
	// Until the pipeline has filled, the outputs are expected to read zero.
	task automatic checkOutputs();
		score_t [`CLASS_COUNT-1:0] expScores;
		classIndex_t expClass;
		expScores = '0;
		expClass = '0;
		if (scoreQ.size() >= scoreDelay)
		begin
			expScores = scoreQ.pop_front();
		end
		if (classQ.size() >= classDelay)
		begin
			expClass = classQ.pop_front();
		end
		checkScore("score0", expScores[0], score0);
		checkScore("score1", expScores[1], score1);
		checkScore("score2", expScores[2], score2);
		checkClass("classIndex", expClass, classIndex);
	endtask

	task automatic applyVector(input activation_t f [`FEATURE_COUNT]);
		score_t [`CLASS_COUNT-1:0] scores;
		classIndex_t best;
		@(negedge clk);
		checkOutputs();
		feature0 = f[0];
		feature1 = f[1];
		feature2 = f[2];
		feature3 = f[3];
		modelVector(f, scores, best);
		scoreQ.push_back(scores);
		classQ.push_back(best);
	endtask

	initial
	begin
		activation_t vec [`FEATURE_COUNT];
		int lane;
		rngState = 32'ha6886318;
		reset = 1'b1;
		feature0 = '0;
		feature1 = '0;
		feature2 = '0;
		feature3 = '0;

		repeat (resetCycles)
		begin
			@(negedge clk);
			checkOutputs(); // Queues are empty, so all outputs must be zero.
		end
		reset = 1'b0;

		// Small features, one vector per clock.
		repeat (smallCount)
		begin
			for (int i = 0; i < `FEATURE_COUNT; i++)
			begin
				vec[i] = nextRandom() & 32'h3fff;
			end
			applyVector(vec);
		end

		// One dominant lane pushes some nodes negative.
		repeat (skewedCount)
		begin
			lane = int'(nextRandom() & 32'd3);
			for (int i = 0; i < `FEATURE_COUNT; i++)
			begin
				vec[i] = nextRandom() & 32'h3f;
			end
			vec[lane] = nextRandom() & 32'h3fff;
			applyVector(vec);
		end

		// All scores zero, so the tie goes to class 0.
		repeat (zeroCount)
		begin
			vec = '{default: '0};
			applyVector(vec);
		end

		// Full-width features wrap the sums.
		repeat (fullCount)
		begin
			for (int i = 0; i < `FEATURE_COUNT; i++)
			begin
				vec[i] = nextRandom();
			end
			applyVector(vec);
		end

		repeat (drainCount)
		begin
			vec = '{default: '0};
			applyVector(vec);
		end

		if (hiddenNegCount == 0 || outputNegCount == 0 || tieCount == 0 || wrapCount == 0)
		begin
			failRun("Stimulus never produced a negative sum, a tie or a wrapped sum.");
		end
		else
		begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule
